/* rtl/argmin_select.sv */
`timescale 1ns/1ns
`include "error_checker_defines.svh"

module argmin_select
    import error_checker_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         pick_en,
    input  energy_word_t energies [`EC_NUM_PATTERNS+1],
    input  bits_word_t   eval_bits,
    input  err_word_t    eval_err,
    output flag_word_t   flags,
    output energy_word_t flag_ener,
    output bits_word_t   bits_out,
    output err_word_t    errors_out,
    output logic         any_flag
);

    flag_word_t   best_flag;
    energy_word_t best_ener;

    // strict less-than, so a tie stays with the lower index
    always_comb begin
        for (int k = 0; k < `EC_LANES; k++) begin
            best_flag[k] = '0;
            best_ener[k] = energies[0][k];
            for (int p = 1; p <= `EC_NUM_PATTERNS; p++) begin
                if (energies[p][k] < best_ener[k]) begin
                    best_ener[k] = energies[p][k];
                    best_flag[k] = flag_t'(p);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (pick_en) begin
            flags <= best_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_en) begin
            flag_ener  <= best_ener;
            bits_out   <= eval_bits;
            errors_out <= eval_err;
        end
    end

    // any lane reporting an event
    always_comb begin
        any_flag = 1'b0;
        for (int k = 0; k < `EC_LANES; k++) begin
            any_flag = any_flag | (flags[k] != '0);
        end
    end

endmodule

/* rtl/error_checker.sv */
`timescale 1ns/1ns
`include "error_checker_defines.svh"

module error_checker
    import error_checker_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  bits_word_t             bits_in,
    input  err_word_t              errors_in,
    input  tap_vec_t               taps,
    output logic                   out_valid,
    output flag_word_t             flags,
    output energy_word_t           flag_ener,
    output bits_word_t             bits_out,
    output err_word_t              errors_out,
    output logic [`EC_COUNT_W-1:0] flag_count
);

    logic         buf_en;
    logic         calc_valid;
    logic         pick_valid;
    logic         any_flag;
    bits_word_t   prev_bits;
    err_word_t    prev_err;
    energy_word_t energies [`EC_NUM_PATTERNS+1];
    bits_word_t   eval_bits;
    err_word_t    eval_err;

    error_checker_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .any_flag   (any_flag),
        .buf_en     (buf_en),
        .calc_valid (calc_valid),
        .pick_valid (pick_valid),
        .out_valid  (out_valid),
        .flag_count (flag_count)
    );

    lane_buffer #(.payload_t(bits_word_t)) bits_buf_i (
        .clk (clk),
        .rst (rst),
        .en  (buf_en),
        .d   (bits_in),
        .q   (prev_bits)
    );

    lane_buffer #(.payload_t(err_word_t)) err_buf_i (
        .clk (clk),
        .rst (rst),
        .en  (buf_en),
        .d   (errors_in),
        .q   (prev_err)
    );

    // current word comes straight from the inputs
    error_energy_calc calc_i (
        .clk       (clk),
        .rst       (rst),
        .calc_en   (calc_valid),
        .prev_bits (prev_bits),
        .cur_bits  (bits_in),
        .prev_err  (prev_err),
        .cur_err   (errors_in),
        .taps      (taps),
        .energies  (energies),
        .eval_bits (eval_bits),
        .eval_err  (eval_err)
    );

    argmin_select pick_i (
        .clk        (clk),
        .rst        (rst),
        .pick_en    (pick_valid),
        .energies   (energies),
        .eval_bits  (eval_bits),
        .eval_err   (eval_err),
        .flags      (flags),
        .flag_ener  (flag_ener),
        .bits_out   (bits_out),
        .errors_out (errors_out),
        .any_flag   (any_flag)
    );

endmodule

/* rtl/error_checker_ctrl.sv */
`timescale 1ns/1ns
`include "error_checker_defines.svh"

module error_checker_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic                   any_flag,
    output logic                   buf_en,
    output logic                   calc_valid,
    output logic                   pick_valid,
    output logic                   out_valid,
    output logic [`EC_COUNT_W-1:0] flag_count
);

    logic primed;

    // buffers take every valid word, gaps just hold them
    assign buf_en = in_valid;

    // previous word can be evaluated once its successor shows up
    assign calc_valid = in_valid & primed;

    always_ff @(posedge clk) begin
        if (rst) begin
            primed <= 1'b0;
        end else if (in_valid) begin
            primed <= 1'b1;
        end
    end

    // one stage per pipeline register
    always_ff @(posedge clk) begin
        if (rst) begin
            pick_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            pick_valid <= calc_valid;
            out_valid  <= pick_valid;
        end
    end

    // flagged words, sticks at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_count <= '0;
        end else if (out_valid && any_flag && (flag_count != '1)) begin
            flag_count <= flag_count + 1'b1;
        end
    end

endmodule

/* rtl/error_checker_defines.svh */
`ifndef ERROR_CHECKER_DEFINES_SVH
`define ERROR_CHECKER_DEFINES_SVH

// lanes per input word
`define EC_LANES 4

// residual and channel tap precision
`define EC_ERR_W 8
`define EC_TAP_W 6
`define EC_TAPS 2

// error event shapes
`define EC_PATTERN_DEPTH 2
`define EC_NUM_PATTERNS 2

// window covers the pattern plus the channel tail
`define EC_SEQ_LEN 3

`define EC_ENER_W 20
// hypothesis 0 plus one per pattern
`define EC_FLAG_W 2
`define EC_COUNT_W 16

`endif

/* rtl/error_checker_pkg.sv */
`include "error_checker_defines.svh"

package error_checker_pkg;

    typedef logic signed [`EC_ERR_W-1:0] err_t;
    typedef logic signed [`EC_TAP_W-1:0] tap_t;
    typedef logic [`EC_ENER_W-1:0] energy_t;

    // 0 means no error, p means flip pattern p
    typedef logic [`EC_FLAG_W-1:0] flag_t;

    // lane 0 is the oldest sample
    typedef logic [`EC_LANES-1:0] bits_word_t;
    typedef err_t [`EC_LANES-1:0] err_word_t;
    typedef tap_t [`EC_TAPS-1:0] tap_vec_t;
    typedef energy_t [`EC_LANES-1:0] energy_word_t;
    typedef flag_t [`EC_LANES-1:0] flag_word_t;

    // bit j set means symbol j of the event is flipped
    typedef logic [`EC_PATTERN_DEPTH-1:0] pattern_t;
    typedef pattern_t [`EC_NUM_PATTERNS:0] pattern_tab_t;

    // entry 0 flips nothing, 1 is a single error, 2 a double error
    localparam pattern_tab_t flip_patterns = {
        2'b11,
        2'b01,
        2'b00
    };

endpackage

/* rtl/error_energy_calc.sv */
`timescale 1ns/1ns
`include "error_checker_defines.svh"

module error_energy_calc
    import error_checker_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         calc_en,
    input  bits_word_t   prev_bits,
    input  bits_word_t   cur_bits,
    input  err_word_t    prev_err,
    input  err_word_t    cur_err,
    input  tap_vec_t     taps,
    output energy_word_t energies [`EC_NUM_PATTERNS+1],
    output bits_word_t   eval_bits,
    output err_word_t    eval_err
);

    localparam int FLAT_LEN = 2 * `EC_LANES;
    localparam int NUM_HYP  = `EC_NUM_PATTERNS + 1;
    // room for the residual plus two doubled taps
    localparam int CORR_W   = `EC_ERR_W + 3;
    localparam int SQ_W     = 2 * CORR_W;

    logic [FLAT_LEN-1:0] flat_bits;
    err_t                flat_err [FLAT_LEN];
    energy_word_t        ener_d   [NUM_HYP];

    // previous word first, then the one just arriving
    assign flat_bits = {cur_bits, prev_bits};

    always_comb begin
        for (int n = 0; n < `EC_LANES; n++) begin
            flat_err[n]             = prev_err[n];
            flat_err[n + `EC_LANES] = cur_err[n];
        end
    end

    always_comb begin : energy_comb
        logic signed [CORR_W-1:0] corr [`EC_SEQ_LEN];
        logic signed [SQ_W-1:0]   sq;
        energy_t                  acc;

        for (int p = 0; p < NUM_HYP; p++) begin
            for (int k = 0; k < `EC_LANES; k++) begin
                for (int j = 0; j < `EC_SEQ_LEN; j++) begin
                    corr[j] = CORR_W'(flat_err[k + j]);
                end
                // flipping s = 2b-1 gives delta = -2s, so e' = e + 2*tap*s
                for (int m = 0; m < `EC_PATTERN_DEPTH; m++) begin
                    for (int t = 0; t < `EC_TAPS; t++) begin
                        if (flip_patterns[p][m]) begin
                            if (flat_bits[k + m]) begin
                                corr[m + t] = corr[m + t] + (CORR_W'(taps[t]) <<< 1);
                            end else begin
                                corr[m + t] = corr[m + t] - (CORR_W'(taps[t]) <<< 1);
                            end
                        end
                    end
                end
                acc = '0;
                for (int j = 0; j < `EC_SEQ_LEN; j++) begin
                    sq  = corr[j] * corr[j];
                    acc = acc + energy_t'($unsigned(sq));
                end
                ener_d[p][k] = acc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_HYP; p++) begin
                energies[p] <= '0;
            end
        end else if (calc_en) begin
            energies <= ener_d;
        end
    end

    // word under test travels with its energies
    always_ff @(posedge clk) begin
        if (calc_en) begin
            eval_bits <= prev_bits;
            eval_err  <= prev_err;
        end
    end

endmodule

/* rtl/lane_buffer.sv */
`timescale 1ns/1ns

module lane_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  payload_t d,
    output payload_t q
);

    // keeps the last accepted word so the detector can look back
    // across the word boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/error_checker_pkg.sv
rtl/lane_buffer.sv
rtl/error_energy_calc.sv
rtl/argmin_select.sv
rtl/error_checker_ctrl.sv
rtl/error_checker.sv
testbench/error_checker_tb.sv

/* testbench/error_checker_tb.sv */
`timescale 1ns/1ns
`include "error_checker_defines.svh"

module error_checker_tb
    import error_checker_pkg::*;
();

    localparam int PERIOD   = 4;
    localparam int MAX_ROWS = 64;
    localparam int NUM_HYP  = `EC_NUM_PATTERNS + 1;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    bits_word_t             bits_in;
    err_word_t              errors_in;
    tap_vec_t               taps;
    logic                   out_valid;
    flag_word_t             flags;
    energy_word_t           flag_ener;
    bits_word_t             bits_out;
    err_word_t              errors_out;
    logic [`EC_COUNT_W-1:0] flag_count;

    // stimulus rows and the expected flags and energies from the model
    int           tab_test  [MAX_ROWS];
    bits_word_t   tab_bits  [MAX_ROWS];
    err_word_t    tab_err   [MAX_ROWS];
    tap_vec_t     tab_taps  [MAX_ROWS];
    int           tab_gap   [MAX_ROWS];
    flag_word_t   tab_flags [MAX_ROWS];
    energy_word_t tab_ener  [MAX_ROWS];
    int           due_cyc   [MAX_ROWS];
    string        test_name [5];
    int           exp_q [$];
    int           nrows;
    int           cyc;
    int           pulses;
    int           checks;
    int           errors;
    int           limit_ns;
    int           mon_idx;
    integer       seed;

    error_checker dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .bits_in    (bits_in),
        .errors_in  (errors_in),
        .taps       (taps),
        .out_valid  (out_valid),
        .flags      (flags),
        .flag_ener  (flag_ener),
        .bits_out   (bits_out),
        .errors_out (errors_out),
        .flag_count (flag_count)
    );

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int sym(input bits_word_t b, input int n);
        return b[n] ? 1 : -1;
    endfunction

    // pattern 1 flips the first symbol and pattern 2 both
    function automatic bit flips(input int p, input int j);
        return (p == 2) || (p == 1 && j == 0);
    endfunction

    task automatic add_row(input int tst, input bits_word_t b, input err_word_t e,
                           input tap_vec_t tp, input int gap);
        tab_test[nrows] = tst;
        tab_bits[nrows] = b;
        tab_err[nrows]  = e;
        tab_taps[nrows] = tp;
        tab_gap[nrows]  = gap;
        nrows++;
    endtask

    // adds the residual that pattern p at this lane leaves behind
    task automatic inject_event(input int r, input int lane, input int p);
        int n;
        int v;
        for (int j = 0; j < `EC_PATTERN_DEPTH; j++) begin
            for (int t = 0; t < `EC_TAPS; t++) begin
                if (flips(p, j)) begin
                    n = lane + j + t;
                    v = $signed(tab_err[r][n])
                        - 2 * sym(tab_bits[r], lane + j) * $signed(tab_taps[r][t]);
                    tab_err[r][n] = err_t'(v);
                end
            end
        end
    endtask

    // reference for word r whose window runs on into word r+1
    task automatic model_row(input int r);
        int s [2*`EC_LANES];
        int e [2*`EC_LANES];
        int d [2*`EC_LANES];
        int ec;
        int ener;
        int best;
        for (int n = 0; n < `EC_LANES; n++) begin
            s[n]             = sym(tab_bits[r], n);
            s[n + `EC_LANES] = sym(tab_bits[r + 1], n);
            e[n]             = $signed(tab_err[r][n]);
            e[n + `EC_LANES] = $signed(tab_err[r + 1][n]);
        end
        for (int k = 0; k < `EC_LANES; k++) begin
            best = -1;
            for (int p = 0; p < NUM_HYP; p++) begin
                for (int n = 0; n < 2 * `EC_LANES; n++) begin
                    d[n] = 0;
                end
                for (int j = 0; j < `EC_PATTERN_DEPTH; j++) begin
                    if (flips(p, j)) begin
                        d[k + j] = -2 * s[k + j];
                    end
                end
                ener = 0;
                for (int n = k; n < k + `EC_SEQ_LEN; n++) begin
                    ec = e[n];
                    for (int t = 0; t < `EC_TAPS && t <= n; t++) begin
                        ec = ec - $signed(tab_taps[r][t]) * d[n - t];
                    end
                    ener = ener + ec * ec;
                end
                // strict compare keeps the lower index on a tie
                if (best < 0 || ener < best) begin
                    best = ener;
                    tab_flags[r][k] = flag_t'(p);
                end
            end
            tab_ener[r][k] = energy_t'(best);
        end
    endtask

    task automatic build_table();
        tap_vec_t   tp;
        bits_word_t rnd_bits;
        int         rnd_gap;
        int         lane;
        int         p;
        tp = {6'sd5, 6'sd12};
        test_name[0] = "first word only";
        add_row(0, 4'b1010, {8'sd3, -8'sd7, 8'sd0, 8'sd5}, tp, 0);
        test_name[1] = "zero residuals";
        add_row(1, 4'b0000, '0, tp, 0);
        add_row(1, 4'b1111, '0, tp, 0);
        add_row(1, 4'b0110, '0, tp, 0);
        add_row(1, 4'b1001, '0, tp, 0);
        test_name[2] = "single events";
        test_name[3] = "events with gaps";
        for (int i = 0; i < 10; i++) begin
            add_row(2 + i / 5, bits_word_t'(i * 7 + 3), '0, tp, (i / 5) * ((i * 3) % 4));
            if (i % 5 != 4) begin
                inject_event(nrows - 1, i % 2, 1 + (i / 2) % 2);
            end
        end
        test_name[4] = "random";
        tp[0] = tap_t'($random(seed) % 16);
        tp[1] = tap_t'($random(seed) % 16);
        for (int i = 0; i < 40; i++) begin
            rnd_bits = bits_word_t'($random(seed));
            rnd_gap  = $unsigned($random(seed)) % 3;
            add_row(4, rnd_bits, '0, tp, rnd_gap);
            lane = $unsigned($random(seed)) % 2;
            p    = 1 + $unsigned($random(seed)) % 2;
            if ($random(seed) & 1) begin
                inject_event(nrows - 1, lane, p);
            end
            // a little noise on top
            for (int k = 0; k < `EC_LANES; k++) begin
                tab_err[nrows - 1][k] = tab_err[nrows - 1][k] + err_t'($random(seed) % 5);
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst      = 1'b1;
        in_valid = 1'b0;
        repeat (2) @(negedge clk);
        rst    = 1'b0;
        pulses = 0;
        checks++;
        if (out_valid !== 1'b0 || flag_count !== '0) begin
            $display("error %0t: out_valid %b flag_count %0d after reset",
                     $time, out_valid, flag_count);
            errors++;
        end
    endtask

    task automatic drive_row(input int r, input bit first);
        repeat (tab_gap[r]) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
        @(negedge clk);
        in_valid  = 1'b1;
        bits_in   = tab_bits[r];
        errors_in = tab_err[r];
        taps      = tab_taps[r];
        // this word releases the previous one two edges later
        if (!first) begin
            due_cyc[r - 1] = cyc + 2;
            exp_q.push_back(r - 1);
        end
    endtask

    task automatic check_output(input int idx);
        checks++;
        if (flags !== tab_flags[idx]) begin
            $display("error %0t: word %0d flags %h, expected %h",
                     $time, idx, flags, tab_flags[idx]);
            errors++;
        end
        if (flag_ener !== tab_ener[idx]) begin
            $display("error %0t: word %0d flag_ener %h, expected %h",
                     $time, idx, flag_ener, tab_ener[idx]);
            errors++;
        end
        if (bits_out !== tab_bits[idx] || errors_out !== tab_err[idx]) begin
            $display("error %0t: word %0d payload %h/%h, expected %h/%h", $time, idx,
                     bits_out, errors_out, tab_bits[idx], tab_err[idx]);
            errors++;
        end
        if (cyc != due_cyc[idx]) begin
            $display("error %0t: word %0d out_valid in cycle %0d, expected %0d",
                     $time, idx, cyc, due_cyc[idx]);
            errors++;
        end
    endtask

    task automatic finish_test(input int t, input int first, input int last,
                               input int err_start);
        int flagged;
        flagged = 0;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d outputs of test %0d never appeared", exp_q.size(), t);
            errors += exp_q.size();
            exp_q.delete();
        end
        for (int r = first; r < last - 1; r++) begin
            if (tab_flags[r] != '0) begin
                flagged++;
            end
        end
        checks += 2;
        if (pulses != last - first - 1) begin
            $display("error %0t: test %0d gave %0d outputs for %0d words",
                     $time, t, pulses, last - first);
            errors++;
        end
        if (flag_count !== `EC_COUNT_W'(flagged)) begin
            $display("error %0t: flag_count %0d, expected %0d", $time, flag_count, flagged);
            errors++;
        end
        $display("test %0d %s: %0d words, %0d outputs, %s", t, test_name[t],
                 last - first, pulses, (errors == err_start) ? "ok" : "failed");
    endtask

    always @(negedge clk) begin
        if (out_valid) begin
            pulses++;
            if (exp_q.size() == 0) begin
                $display("out_valid at %0t with no word waiting to come out", $time);
                errors++;
            end else begin
                mon_idx = exp_q.pop_front();
                check_output(mon_idx);
            end
        end
    end

    // stops a stuck run after a budget that scales with rows, gaps and tests
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: run still going after %0d ns", limit_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int r;
        int first;
        int err_start;
        int gaps;
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        bits_in   = '0;
        errors_in = '0;
        taps      = '0;
        cyc       = 0;
        nrows     = 0;
        checks    = 0;
        errors    = 0;
        seed      = 32'h2137_f717;
        build_table();
        gaps = 0;
        for (r = 0; r < nrows; r++) begin
            gaps += tab_gap[r];
            if (r + 1 < nrows && tab_test[r + 1] == tab_test[r]) begin
                model_row(r);
            end
        end
        limit_ns = (nrows + gaps + 10 * 5 + 20) * PERIOD;
        r = 0;
        while (r < nrows) begin
            first     = r;
            err_start = errors;
            apply_reset();
            while (r < nrows && tab_test[r] == tab_test[first]) begin
                drive_row(r, r == first);
                r++;
            end
            finish_test(tab_test[first], first, r, err_start);
        end
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
